// ==== hb_adder_tree.sv ====
`default_nettype none

module hb_adder_tree (
    input  wire                         i_clock,
    input  wire                         i_reset,
    input  wire                         i_valid,
    input  wire hb_decim_pkg::iq_acc_t  i_products [hb_decim_pkg::NUM_PAIRS],
    input  wire hb_decim_pkg::iq_sample_t i_center,
    output hb_decim_pkg::iq_acc_t       o_sum,
    output hb_decim_pkg::iq_sample_t    o_center,
    output logic                        o_valid
);

    import hb_decim_pkg::*;

    iq_acc_t    level1 [NUM_PAIRS/2];
    iq_acc_t    level2 [NUM_PAIRS/4];
    iq_sample_t center_l1;
    iq_sample_t center_l2;
    logic       valid_l1;
    logic       valid_l2;

    function automatic iq_acc_t acc_add(input iq_acc_t a, input iq_acc_t b);
        iq_acc_t s;
        s.inph = a.inph + b.inph;
        s.quad = a.quad + b.quad;
        return s;
    endfunction

    // Eight products to four, four to two, two to one
    always_ff @(posedge i_clock) begin
        for (int j = 0; j < NUM_PAIRS/2; j++) begin
            level1[j] <= acc_add(i_products[2*j], i_products[2*j+1]);
        end
        for (int j = 0; j < NUM_PAIRS/4; j++) begin
            level2[j] <= acc_add(level1[2*j], level1[2*j+1]);
        end
        o_sum <= acc_add(level2[0], level2[1]);

        // Center tap rides along with the tree
        center_l1 <= i_center;
        center_l2 <= center_l1;
        o_center  <= center_l2;
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            valid_l1 <= 1'b0;
            valid_l2 <= 1'b0;
            o_valid  <= 1'b0;
        end else begin
            valid_l1 <= i_valid;
            valid_l2 <= valid_l1;
            o_valid  <= valid_l2;
        end
    end

endmodule

`default_nettype wire

// ==== hb_decim_fir.sv ====
`default_nettype none

module hb_decim_fir (
    input  wire                      i_clock,
    input  wire                      i_reset,
    input  wire hb_decim_pkg::sample_t i_inph_data,
    input  wire hb_decim_pkg::sample_t i_quad_data,
    input  wire                      i_valid,
    output hb_decim_pkg::sample_t    o_inph_data,
    output hb_decim_pkg::sample_t    o_quad_data,
    output logic                     o_valid
);

    import hb_decim_pkg::*;

    iq_sample_t in_sample;
    iq_sample_t taps [NUM_TAPS];
    iq_sample_t tdl_center;
    logic       tdl_valid;
    iq_acc_t    products [NUM_PAIRS];
    iq_sample_t mult_center;
    logic       mult_valid;
    iq_acc_t    tree_sum;
    iq_sample_t tree_center;
    logic       tree_valid;
    iq_sample_t out_sample;

    assign in_sample.inph = i_inph_data;
    assign in_sample.quad = i_quad_data;

    hb_polyphase_tdl u_tdl (
        .i_clock  (i_clock),
        .i_reset  (i_reset),
        .i_valid  (i_valid),
        .i_sample (in_sample),
        .o_taps   (taps),
        .o_center (tdl_center),
        .o_valid  (tdl_valid)
    );

    hb_preadd_mult u_preadd_mult (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_valid    (tdl_valid),
        .i_taps     (taps),
        .i_center   (tdl_center),
        .o_products (products),
        .o_center   (mult_center),
        .o_valid    (mult_valid)
    );

    hb_adder_tree u_adder_tree (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_valid    (mult_valid),
        .i_products (products),
        .i_center   (mult_center),
        .o_sum      (tree_sum),
        .o_center   (tree_center),
        .o_valid    (tree_valid)
    );

    hb_round_sat u_round_sat (
        .i_clock  (i_clock),
        .i_reset  (i_reset),
        .i_valid  (tree_valid),
        .i_sum    (tree_sum),
        .i_center (tree_center),
        .o_sample (out_sample),
        .o_valid  (o_valid)
    );

    assign o_inph_data = out_sample.inph;
    assign o_quad_data = out_sample.quad;

endmodule

`default_nettype wire

// ==== hb_decim_pkg.sv ====
`default_nettype none

package hb_decim_pkg;

    // Sample and coefficient formats
    localparam int SAMPLE_W  = 16;
    localparam int COEF_W    = 18;
    localparam int FRAC_BITS = 18;

    // Filter geometry
    localparam int NUM_TAPS   = 16;
    localparam int NUM_PAIRS  = 8;
    localparam int ODD_DEPTH  = 8;
    localparam int CENTER_POS = 7;

    // Wide enough for the full sum plus the weighted center tap
    localparam int ACC_W = 40;

    typedef logic signed [COEF_W-1:0] coef_t;

    // Entry k weights even taps k and NUM_TAPS-1-k, outermost pair first
    localparam coef_t COEFS [NUM_PAIRS] = '{
        -3051,
        4112,
        -5533,
        7520,
        -10511,
        16650,
        -27184,
        83231
    };

    typedef logic signed [SAMPLE_W-1:0] sample_t;

    typedef struct packed {
        sample_t inph;
        sample_t quad;
    } iq_sample_t;

    // Pre-adder result, one bit of growth
    typedef struct packed {
        logic signed [SAMPLE_W:0] inph;
        logic signed [SAMPLE_W:0] quad;
    } iq_sum_t;

    typedef struct packed {
        logic signed [ACC_W-1:0] inph;
        logic signed [ACC_W-1:0] quad;
    } iq_acc_t;

    // Commutator state
    typedef enum logic {
        PHASE_EVEN,
        PHASE_ODD
    } phase_t;

endpackage

`default_nettype wire

// ==== hb_polyphase_tdl.sv ====
`default_nettype none

module hb_polyphase_tdl (
    input  wire                         i_clock,
    input  wire                         i_reset,
    input  wire                         i_valid,
    input  wire hb_decim_pkg::iq_sample_t i_sample,
    output hb_decim_pkg::iq_sample_t    o_taps [hb_decim_pkg::NUM_TAPS],
    output hb_decim_pkg::iq_sample_t    o_center,
    output logic                        o_valid
);

    import hb_decim_pkg::*;

    phase_t     phase;
    iq_sample_t even_line [NUM_TAPS];
    iq_sample_t odd_line [ODD_DEPTH];
    logic       accept_even;
    logic       accept_odd;

    assign accept_even = i_valid && (phase == PHASE_EVEN);
    assign accept_odd  = i_valid && (phase == PHASE_ODD);

    // Commutator, toggles once per accepted sample
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            phase <= PHASE_EVEN;
        end else if (i_valid) begin
            phase <= (phase == PHASE_EVEN) ? PHASE_ODD : PHASE_EVEN;
        end
    end

    // Even-phase line, position 0 is the newest sample
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            for (int i = 0; i < NUM_TAPS; i++) begin
                even_line[i] <= '0;
            end
        end else if (accept_even) begin
            even_line[0] <= i_sample;
            for (int i = 1; i < NUM_TAPS; i++) begin
                even_line[i] <= even_line[i-1];
            end
        end
    end

    // Odd-phase line only feeds the center tap
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            for (int i = 0; i < ODD_DEPTH; i++) begin
                odd_line[i] <= '0;
            end
        end else if (accept_odd) begin
            odd_line[0] <= i_sample;
            for (int i = 1; i < ODD_DEPTH; i++) begin
                odd_line[i] <= odd_line[i-1];
            end
        end
    end

    // One output per even sample
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= accept_even;
        end
    end

    assign o_taps   = even_line;
    assign o_center = odd_line[CENTER_POS];

endmodule

`default_nettype wire

// ==== hb_preadd_mult.sv ====
`default_nettype none

module hb_preadd_mult (
    input  wire                         i_clock,
    input  wire                         i_reset,
    input  wire                         i_valid,
    input  wire hb_decim_pkg::iq_sample_t i_taps [hb_decim_pkg::NUM_TAPS],
    input  wire hb_decim_pkg::iq_sample_t i_center,
    output hb_decim_pkg::iq_acc_t       o_products [hb_decim_pkg::NUM_PAIRS],
    output hb_decim_pkg::iq_sample_t    o_center,
    output logic                        o_valid
);

    import hb_decim_pkg::*;

    iq_sum_t    pair_sum [NUM_PAIRS];
    iq_sample_t center_d;
    logic       valid_d;

    // Symmetric pre-add, taps k and NUM_TAPS-1-k share a coefficient
    always_ff @(posedge i_clock) begin
        for (int k = 0; k < NUM_PAIRS; k++) begin
            pair_sum[k].inph <= i_taps[k].inph + i_taps[NUM_TAPS-1-k].inph;
            pair_sum[k].quad <= i_taps[k].quad + i_taps[NUM_TAPS-1-k].quad;
        end
        center_d <= i_center;
    end

    // Constant multipliers, sign extended to the accumulator width
    always_ff @(posedge i_clock) begin
        for (int k = 0; k < NUM_PAIRS; k++) begin
            o_products[k].inph <= pair_sum[k].inph * COEFS[k];
            o_products[k].quad <= pair_sum[k].quad * COEFS[k];
        end
        o_center <= center_d;
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            valid_d <= 1'b0;
            o_valid <= 1'b0;
        end else begin
            valid_d <= i_valid;
            o_valid <= valid_d;
        end
    end

endmodule

`default_nettype wire

// ==== hb_round_sat.sv ====
`default_nettype none

module hb_round_sat (
    input  wire                         i_clock,
    input  wire                         i_reset,
    input  wire                         i_valid,
    input  wire hb_decim_pkg::iq_acc_t  i_sum,
    input  wire hb_decim_pkg::iq_sample_t i_center,
    output hb_decim_pkg::iq_sample_t    o_sample,
    output logic                        o_valid
);

    import hb_decim_pkg::*;

    iq_acc_t rounded;
    logic    rounded_valid;

    // Center tap has unit gain, i.e. 2^FRAC_BITS in coefficient units,
    // plus half an output LSB for round half-up
    function automatic logic signed [ACC_W-1:0] add_center(
        input logic signed [ACC_W-1:0] sum,
        input sample_t                 center
    );
        logic signed [ACC_W-1:0] center_term;
        logic signed [ACC_W-1:0] half_lsb;
        center_term = ACC_W'(center) <<< FRAC_BITS;
        half_lsb    = ACC_W'(1) <<< (FRAC_BITS - 1);
        return sum + center_term + half_lsb;
    endfunction

    // Pass the output field unless the upper bits are not all sign
    function automatic sample_t saturate(input logic signed [ACC_W-1:0] acc);
        logic [ACC_W-SAMPLE_W-FRAC_BITS:0] top;
        top = acc[ACC_W-1:FRAC_BITS+SAMPLE_W-1];
        if ((&top) || !(|top)) begin
            return acc[FRAC_BITS+SAMPLE_W-1:FRAC_BITS];
        end else if (acc[ACC_W-1]) begin
            return {1'b1, {(SAMPLE_W-1){1'b0}}};
        end else begin
            return {1'b0, {(SAMPLE_W-1){1'b1}}};
        end
    endfunction

    always_ff @(posedge i_clock) begin
        rounded.inph <= add_center(i_sum.inph, i_center.inph);
        rounded.quad <= add_center(i_sum.quad, i_center.quad);
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            rounded_valid <= 1'b0;
            o_valid       <= 1'b0;
            o_sample      <= '0;
        end else begin
            rounded_valid <= i_valid;
            o_valid       <= rounded_valid;
            if (rounded_valid) begin
                o_sample.inph <= saturate(rounded.inph);
                o_sample.quad <= saturate(rounded.quad);
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb.f ====
hb_decim_pkg.sv
hb_polyphase_tdl.sv
hb_preadd_mult.sv
hb_adder_tree.sv
hb_round_sat.sv
hb_decim_fir.sv
tb_hb_decim.sv

// ==== tb_hb_decim.sv ====
`default_nettype none

module tb_hb_decim;

    import hb_decim_pkg::*;

    typedef int tap_hist_t [NUM_TAPS];

    // One expected output and the edge that accepted its even sample
    typedef struct packed {
        sample_t inph;
        sample_t quad;
        int      acc_edge;
    } expect_t;

    logic    i_clock;
    logic    i_reset;
    logic    i_valid;
    sample_t i_inph_data;
    sample_t i_quad_data;
    sample_t o_inph_data;
    sample_t o_quad_data;
    logic    o_valid;

    int        seed;
    int        edge_count;
    int        mismatch_errors;
    int        other_errors;
    int        evens_sent;
    int        outputs_seen;
    bit        sat_hi_seen;
    bit        sat_lo_seen;
    bit        model_odd;
    tap_hist_t even_i;
    tap_hist_t even_q;
    int        odd_i [ODD_DEPTH];
    int        odd_q [ODD_DEPTH];
    expect_t   exp_q [$];

    hb_decim_fir uut (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_inph_data (i_inph_data),
        .i_quad_data (i_quad_data),
        .i_valid     (i_valid),
        .o_inph_data (o_inph_data),
        .o_quad_data (o_quad_data),
        .o_valid     (o_valid)
    );

    always #5 i_clock = ~i_clock;

    always @(posedge i_clock) begin
        edge_count <= edge_count + 1;
    end

    // Half-band rule: pair sums, unit center tap, round half-up, clamp
    function automatic int filter_ref(input tap_hist_t taps, input int center);
        longint acc;
        acc = longint'(center) <<< FRAC_BITS;
        acc = acc + (longint'(1) <<< (FRAC_BITS - 1));
        for (int k = 0; k < NUM_PAIRS; k++) begin
            acc = acc + longint'(COEFS[k]) * longint'(taps[k] + taps[NUM_TAPS-1-k]);
        end
        acc = acc >>> FRAC_BITS;
        if (acc > 32767) begin
            return 32767;
        end else if (acc < -32768) begin
            return -32768;
        end
        return int'(acc);
    endfunction

    task automatic clear_model();
        model_odd = 1'b0;
        for (int i = 0; i < NUM_TAPS; i++) begin
            even_i[i] = 0;
            even_q[i] = 0;
        end
        for (int i = 0; i < ODD_DEPTH; i++) begin
            odd_i[i] = 0;
            odd_q[i] = 0;
        end
    endtask

    // Commutator model, the sample lands at the next edge
    task automatic model_accept(input int inph, input int quad);
        expect_t e;
        if (!model_odd) begin
            for (int i = NUM_TAPS-1; i > 0; i--) begin
                even_i[i] = even_i[i-1];
                even_q[i] = even_q[i-1];
            end
            even_i[0]  = inph;
            even_q[0]  = quad;
            e.inph     = sample_t'(filter_ref(even_i, odd_i[CENTER_POS]));
            e.quad     = sample_t'(filter_ref(even_q, odd_q[CENTER_POS]));
            e.acc_edge = edge_count + 1;
            exp_q.push_back(e);
            evens_sent++;
        end else begin
            for (int i = ODD_DEPTH-1; i > 0; i--) begin
                odd_i[i] = odd_i[i-1];
                odd_q[i] = odd_q[i-1];
            end
            odd_i[0] = inph;
            odd_q[0] = quad;
        end
        model_odd = !model_odd;
    endtask

    task automatic send(input bit v, input int inph, input int quad);
        @(posedge i_clock);
        i_valid     <= v;
        i_inph_data <= sample_t'(inph);
        i_quad_data <= sample_t'(quad);
        if (v) begin
            model_accept(inph, quad);
        end
    endtask

    function automatic int rand_sample();
        int r;
        r = $random(seed);
        return int'(sample_t'(r));
    endfunction

    task automatic send_random(input int count, input int pct);
        int unsigned r;
        bit          v;
        for (int n = 0; n < count; n++) begin
            r = $random(seed);
            v = (r % 100) < pct;
            send(v, rand_sample(), rand_sample());
        end
    endtask

    task automatic apply_reset(input int cycles);
        @(posedge i_clock);
        i_reset <= 1'b1;
        i_valid <= 1'b0;
        clear_model();
        repeat (cycles) @(posedge i_clock);
        i_reset <= 1'b0;
    endtask

    task automatic wait_outputs();
        int waited;
        send(1'b0, 0, 0);
        waited = 0;
        while (exp_q.size() > 0 && waited < 100) begin
            @(posedge i_clock);
            waited++;
        end
        if (exp_q.size() > 0) begin
            other_errors++;
            $display("Timed out at %0t with %0d outputs still pending", $time, exp_q.size());
        end
    endtask

    always @(posedge i_clock) begin : compare_outputs
        expect_t e;
        if (o_valid) begin
            outputs_seen++;
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("Unexpected o_valid at %0t with no output pending", $time);
            end else begin
                e = exp_q.pop_front();
                if (o_inph_data !== e.inph) begin
                    mismatch_errors++;
                    $display("Mismatch at %0t: o_inph_data got %0d expected %0d",
                             $time, o_inph_data, e.inph);
                end
                if (o_quad_data !== e.quad) begin
                    mismatch_errors++;
                    $display("Mismatch at %0t: o_quad_data got %0d expected %0d",
                             $time, o_quad_data, e.quad);
                end
                if (edge_count - 1 - e.acc_edge != 7) begin
                    other_errors++;
                    $display("o_valid at %0t came %0d edges after its sample instead of 7",
                             $time, edge_count - 1 - e.acc_edge);
                end
            end
            if (o_inph_data == 32767) begin
                sat_hi_seen = 1'b1;
            end
            if (o_quad_data == -32768) begin
                sat_lo_seen = 1'b1;
            end
        end
        // Anything due at or after a reset edge is dropped by the DUT
        if (i_reset) begin
            while (exp_q.size() > 0 && exp_q[$].acc_edge + 7 >= edge_count) begin
                void'(exp_q.pop_back());
            end
        end
    end

    initial begin : main
        int start_evens;
        int start_outs;
        int s;
        seed            = 32'h44a4d6e7;
        i_clock         = 1'b0;
        i_reset         = 1'b1;
        i_valid         = 1'b0;
        i_inph_data     = '0;
        i_quad_data     = '0;
        edge_count      = 0;
        mismatch_errors = 0;
        other_errors    = 0;
        evens_sent      = 0;
        outputs_seen    = 0;
        sat_hi_seen     = 1'b0;
        sat_lo_seen     = 1'b0;
        clear_model();
        repeat (5) @(posedge i_clock);
        i_reset <= 1'b0;

        // Even-phase impulse, then 39 zeros so the next sample is even again
        send(1'b1, 8192, 0);
        repeat (39) send(1'b1, 0, 0);
        send(1'b1, 0, 0);
        send(1'b1, 8192, 0);
        repeat (40) send(1'b1, 0, 0);
        wait_outputs();

        start_evens = evens_sent;
        start_outs  = outputs_seen;
        send_random(200, 100);
        wait_outputs();
        if (outputs_seen - start_outs != evens_sent - start_evens) begin
            other_errors++;
            $display("Got %0d outputs for %0d even samples",
                     outputs_seen - start_outs, evens_sent - start_evens);
        end

        send_random(300, 60);
        wait_outputs();

        // Signs follow the coefficients so the sum overflows both ways
        sat_hi_seen = 1'b0;
        sat_lo_seen = 1'b0;
        if (model_odd) begin
            send(1'b1, 0, 0);
        end
        for (int m = 0; m < NUM_TAPS; m++) begin
            s = (COEFS[(m < NUM_PAIRS) ? m : NUM_TAPS-1-m] < 0) ? -32767 : 32767;
            send(1'b1, s, -s);
            send(1'b1, 32767, -32767);
        end
        repeat (40) send(1'b1, 0, 0);
        wait_outputs();
        if (!sat_hi_seen || !sat_lo_seen) begin
            other_errors++;
            $display("Outputs never clamped to both 32767 and -32768");
        end

        send_random(37, 100);
        apply_reset(3);
        send_random(60, 100);
        wait_outputs();

        $display("Errors: %0d value mismatches, %0d other failures",
                 mismatch_errors, other_errors);
        if (mismatch_errors + other_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
